// ==== tb.f ====
core_pkg.sv
ctrl_pkg.sv
operand_buf.sv
exec_ctrl.sv
mac_array.sv
sync_fifo.sv
store_ctrl.sv
proc_core.sv
tb_clk_gen.sv
tb_proc_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_proc_core
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJDIR)

// ==== tb_proc_core.sv ====
`timescale 1ns/1ns

module tb_proc_core import core_pkg::*, ctrl_pkg::*;;

    localparam int TAPU_NUM  = 2;
    localparam int ROWS      = 2;
    localparam int COLS      = 4;
    localparam int BUF_DEPTH = 16;
    localparam int OUT_DEPTH = 8;
    localparam int X_W       = TAPU_NUM * ROWS * OPND_W;
    localparam int Y_W       = COLS * OPND_W;
    localparam int CW        = COLS * PSUM_W;
    localparam int NW        = TAPU_NUM * ROWS;

    // enough stores to fill the stream fifo, plus one that has to wait
    localparam int BP_STORES = OUT_DEPTH / NW + 1;

    // worst-case cycles per step, summed over all load/exec/store runs
    localparam int RESET_CYC  = 12;
    localparam int LOAD_MAX   = BUF_DEPTH + 4;
    localparam int EXEC_MAX   = BUF_DEPTH + ROWS + 8;
    localparam int STORE_MAX  = 160;
    localparam int RUNS       = 4 + BP_STORES;
    localparam int TIMEOUT_NS =
        2 * (RESET_CYC + RUNS * (LOAD_MAX + EXEC_MAX + STORE_MAX + 4)) * 20;

    logic clk;
    logic rst_n;
    logic i_x_valid;
    logic o_x_ready;
    logic [X_W-1:0] i_x_data;
    logic i_x_last;
    logic i_y_valid;
    logic o_y_ready;
    logic [Y_W-1:0] i_y_data;
    logic i_y_last;
    logic o_loadx_done;
    logic o_loady_done;
    logic i_exec_start;
    logic i_psu_clr;
    cnt_t i_depth;
    logic o_exec_done;
    logic i_store_start;
    logic o_store_done;
    logic o_m_valid;
    logic i_m_ready;
    logic [CW-1:0] o_m_data;
    logic o_m_last;

    integer seed = 32'h36f1_e4fe;
    int     errors = 0;
    int     checks = 0;

    // reference state: operand copies and accumulators
    logic [X_W-1:0] xm [BUF_DEPTH];
    logic [Y_W-1:0] ym [BUF_DEPTH];
    int             acc_m [TAPU_NUM][ROWS][COLS];

    // expected stream words in order, last flag on top
    logic [CW:0]    exp_q [$];

    tb_clk_gen #(
        .HALF_PERIOD (10),
        .RESET_CYCLES(10)
    ) u_clk_gen (
        .clk  (clk),
        .rst_n(rst_n)
    );

    proc_core #(
        .TAPU_NUM      (TAPU_NUM),
        .ROWS          (ROWS),
        .COLS          (COLS),
        .BUF_DEPTH     (BUF_DEPTH),
        .RES_FIFO_DEPTH(4),
        .OUT_FIFO_DEPTH(OUT_DEPTH)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_x_valid    (i_x_valid),
        .o_x_ready    (o_x_ready),
        .i_x_data     (i_x_data),
        .i_x_last     (i_x_last),
        .i_y_valid    (i_y_valid),
        .o_y_ready    (o_y_ready),
        .i_y_data     (i_y_data),
        .i_y_last     (i_y_last),
        .o_loadx_done (o_loadx_done),
        .o_loady_done (o_loady_done),
        .i_exec_start (i_exec_start),
        .i_psu_clr    (i_psu_clr),
        .i_depth      (i_depth),
        .o_exec_done  (o_exec_done),
        .i_store_start(i_store_start),
        .o_store_done (o_store_done),
        .o_m_valid    (o_m_valid),
        .i_m_ready    (i_m_ready),
        .o_m_data     (o_m_data),
        .o_m_last     (o_m_last)
    );

    task automatic check_value(input logic [CW-1:0] actual, input logic [CW-1:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // random int8, mostly -128 or 127 when extreme is set
    function automatic opnd_t rand_elem(input bit extreme);
        logic [31:0] rnd;
        rnd = $random(seed);
        if (extreme && rnd[9:8] != 2'b11) begin
            return rnd[10] ? opnd_t'(8'h7f) : opnd_t'(8'h80);
        end
        return opnd_t'(rnd[7:0]);
    endfunction

    // cell (t,r,c) sums x element t*ROWS+r times y element c over k
    task automatic model_exec(input int k, input bit clr);
        int xe;
        int ye;
        for (int t = 0; t < TAPU_NUM; t++) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    if (clr) begin
                        acc_m[t][r][c] = 0;
                    end
                    for (int kk = 0; kk < k; kk++) begin
                        xe = int'(opnd_t'(xm[kk][(t*ROWS+r)*OPND_W +: OPND_W]));
                        ye = int'(opnd_t'(ym[kk][c*OPND_W +: OPND_W]));
                        acc_m[t][r][c] = acc_m[t][r][c] + xe * ye;
                    end
                end
            end
        end
    endtask

    function automatic logic [CW-1:0] expected_word(input int t, input int r);
        logic [CW-1:0] w;
        for (int c = 0; c < COLS; c++) begin
            w[c*PSUM_W +: PSUM_W] = acc_m[t][r][c];
        end
        return w;
    endfunction

    // X and Y beats go in side by side; each done must pulse once
    task automatic load_operands(input int k, input bit extreme);
        int xdone;
        int ydone;
        xdone = 0;
        ydone = 0;
        for (int i = 0; i < k; i++) begin
            for (int e = 0; e < TAPU_NUM * ROWS; e++) begin
                xm[i][e*OPND_W +: OPND_W] = rand_elem(extreme);
            end
            for (int e = 0; e < COLS; e++) begin
                ym[i][e*OPND_W +: OPND_W] = rand_elem(extreme);
            end
            @(negedge clk);
            xdone += int'(o_loadx_done);
            ydone += int'(o_loady_done);
            i_x_valid = 1'b1;
            i_y_valid = 1'b1;
            i_x_data  = xm[i];
            i_y_data  = ym[i];
            i_x_last  = (i == k - 1);
            i_y_last  = (i == k - 1);
        end
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            xdone += int'(o_loadx_done);
            ydone += int'(o_loady_done);
            i_x_valid = 1'b0;
            i_y_valid = 1'b0;
            i_x_last  = 1'b0;
            i_y_last  = 1'b0;
        end
        check_value(CW'(xdone), CW'(1), "x load done pulses");
        check_value(CW'(ydone), CW'(1), "y load done pulses");
    endtask

    task automatic run_exec(input int k, input bit clr);
        int cycles;
        model_exec(k, clr);
        @(negedge clk);
        i_depth      = cnt_t'(k);
        i_psu_clr    = clr;
        i_exec_start = 1'b1;
        @(negedge clk);
        i_exec_start = 1'b0;
        i_psu_clr    = 1'b0;
        cycles = 0;
        while (!o_exec_done && cycles < EXEC_MAX) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_exec_done) begin
            errors++;
            $display("execution with depth %0d never signalled done", k);
        end
    endtask

    // array-then-row order, last on the final word of this store
    task automatic start_store();
        for (int w = 0; w < NW; w++) begin
            exp_q.push_back({w == NW - 1, expected_word(w / ROWS, w % ROWS)});
        end
        @(negedge clk);
        i_store_start = 1'b1;
        @(negedge clk);
        i_store_start = 1'b0;
    endtask

    // a store that still fits in the stream fifo finishes without a reader
    task automatic wait_store_done();
        int cycles;
        cycles = 0;
        while (!o_store_done && cycles < STORE_MAX) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_store_done) begin
            errors++;
            $display("store did not finish while the stream fifo had room");
        end
    endtask

    // words are taken at the falling edge before the rising edge that moves them
    task automatic drain_stream(input bit backpressure);
        int          got;
        int          total;
        int          limit;
        int          done_cnt;
        int          cycles;
        int          stall;
        logic        ready;
        logic [31:0] rnd;
        logic [CW:0] exp_w;
        got      = 0;
        total    = exp_q.size();
        limit    = STORE_MAX * (total / NW);
        done_cnt = 0;
        cycles   = 0;
        stall    = backpressure ? 12 : 0;
        while ((got < total || done_cnt == 0) && cycles < limit) begin
            done_cnt += int'(o_store_done);
            rnd = $random(seed);
            if (!backpressure) begin
                ready = 1'b1;
            end else if (stall > 0) begin
                ready = 1'b0;
                stall--;
            end else begin
                ready = rnd[0];
                if (rnd[5:3] == 3'd0) begin
                    stall = 8 + int'(rnd[9:6]);
                end
            end
            i_m_ready = ready;
            if (o_m_valid && ready) begin
                if (exp_q.size() > 0) begin
                    exp_w = exp_q.pop_front();
                    check_value(o_m_data, exp_w[CW-1:0],
                                $sformatf("stream word %0d data", got));
                    check_value(CW'(o_m_last), CW'(exp_w[CW]),
                                $sformatf("stream word %0d last", got));
                end
                got++;
            end
            @(negedge clk);
            cycles++;
        end
        if (got < total || done_cnt == 0) begin
            errors++;
            $display("store stalled: %0d of %0d words, done seen %0d times",
                     got, total, done_cnt);
        end
        exp_q.delete();
        i_m_ready = 1'b1;
        repeat (3) begin
            @(negedge clk);
            done_cnt += int'(o_store_done);
            check_value(CW'(o_m_valid), CW'(0), "stream idle after last word");
        end
        check_value(CW'(got), CW'(total), "stored word count");
        check_value(CW'(done_cnt), CW'(1), "store done pulses");
    endtask

    task automatic store_and_check(input bit backpressure);
        start_store();
        drain_stream(backpressure);
    endtask

    task automatic test_reset_state();
        check_value(CW'(o_m_valid), CW'(0), "o_m_valid after reset");
        check_value(CW'(o_m_last), CW'(0), "o_m_last after reset");
        check_value(CW'(o_exec_done), CW'(0), "o_exec_done after reset");
        check_value(CW'(o_store_done), CW'(0), "o_store_done after reset");
        check_value(CW'(o_loadx_done), CW'(0), "o_loadx_done after reset");
        check_value(CW'(o_loady_done), CW'(0), "o_loady_done after reset");
        check_value(CW'(o_x_ready), CW'(1), "o_x_ready after reset");
        check_value(CW'(o_y_ready), CW'(1), "o_y_ready after reset");
    endtask

    task automatic test_cleared_run();
        load_operands(4, 1'b0);
        run_exec(4, 1'b1);
        store_and_check(1'b0);
    endtask

    task automatic test_accumulate();
        load_operands(4, 1'b0);
        run_exec(4, 1'b0);
        store_and_check(1'b0);
    endtask

    // stream held off until the fifo is full and the last store has to wait
    task automatic test_backpressure();
        i_m_ready = 1'b0;
        for (int n = 0; n < BP_STORES; n++) begin
            load_operands(6, 1'b0);
            run_exec(6, 1'b1);
            start_store();
            if (n < BP_STORES - 1) begin
                wait_store_done();
            end
        end
        drain_stream(1'b1);
    endtask

    task automatic test_depth_edges();
        load_operands(1, 1'b1);
        run_exec(1, 1'b1);
        store_and_check(1'b0);
        load_operands(BUF_DEPTH, 1'b1);
        run_exec(BUF_DEPTH, 1'b1);
        store_and_check(1'b0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        i_x_valid     = 1'b0;
        i_x_data      = '0;
        i_x_last      = 1'b0;
        i_y_valid     = 1'b0;
        i_y_data      = '0;
        i_y_last      = 1'b0;
        i_exec_start  = 1'b0;
        i_psu_clr     = 1'b0;
        i_depth       = cnt_t'(1);
        i_store_start = 1'b0;
        i_m_ready     = 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        test_reset_state();
        test_cleared_run();
        test_accumulate();
        test_backpressure();
        test_depth_edges();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== proc_core.sv ====
`timescale 1ns/1ns

module proc_core import core_pkg::*, ctrl_pkg::*; #(
    parameter int TAPU_NUM       = 2,
    parameter int ROWS           = 2,
    parameter int COLS           = 4,
    parameter int BUF_DEPTH      = 16,
    parameter int RES_FIFO_DEPTH = 4,
    parameter int OUT_FIFO_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // x operand load
    input  logic                              i_x_valid,
    output logic                              o_x_ready,
    input  logic [TAPU_NUM*ROWS*OPND_W-1:0]   i_x_data,
    input  logic                              i_x_last,
    // y operand load
    input  logic                              i_y_valid,
    output logic                              o_y_ready,
    input  logic [COLS*OPND_W-1:0]            i_y_data,
    input  logic                              i_y_last,
    output logic                              o_loadx_done,
    output logic                              o_loady_done,
    // execution
    input  logic                              i_exec_start,
    input  logic                              i_psu_clr,
    input  cnt_t                              i_depth,
    output logic                              o_exec_done,
    // store
    input  logic                              i_store_start,
    output logic                              o_store_done,
    // output stream
    output logic                              o_m_valid,
    input  logic                              i_m_ready,
    output logic [COLS*PSUM_W-1:0]            o_m_data,
    output logic                              o_m_last
);

    localparam int X_W   = TAPU_NUM * ROWS * OPND_W;
    localparam int Y_W   = COLS * OPND_W;
    localparam int RES_W = COLS * PSUM_W;

    logic [X_W-1:0]                 x_rd_data;
    logic [Y_W-1:0]                 y_rd_data;
    cnt_t                           rd_addr;
    logic                           acc_en;
    logic                           clr;
    cnt_t                           drain_row;
    logic                           drain_wr;
    logic [TAPU_NUM-1:0][RES_W-1:0] row_data;
    logic [TAPU_NUM-1:0][RES_W-1:0] res_dout;
    logic [TAPU_NUM-1:0]            res_rd;
    logic                           out_full;
    logic                           out_empty;
    logic                           out_wr;
    logic [RES_W-1:0]               out_data;
    logic                           out_last;

    operand_buf #(
        .WIDTH(X_W),
        .DEPTH(BUF_DEPTH)
    ) x_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (i_x_valid),
        .o_ready    (o_x_ready),
        .i_data     (i_x_data),
        .i_last     (i_x_last),
        .o_load_done(o_loadx_done),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (x_rd_data)
    );

    operand_buf #(
        .WIDTH(Y_W),
        .DEPTH(BUF_DEPTH)
    ) y_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (i_y_valid),
        .o_ready    (o_y_ready),
        .i_data     (i_y_data),
        .i_last     (i_y_last),
        .o_load_done(o_loady_done),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (y_rd_data)
    );

    exec_ctrl #(
        .ROWS     (ROWS),
        .BUF_DEPTH(BUF_DEPTH)
    ) u_exec_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_exec_start(i_exec_start),
        .i_psu_clr   (i_psu_clr),
        .i_depth     (i_depth),
        .o_rd_addr   (rd_addr),
        .o_acc_en    (acc_en),
        .o_clr       (clr),
        .o_drain_row (drain_row),
        .o_drain_wr  (drain_wr),
        .o_exec_done (o_exec_done)
    );

    // each array takes its own ROWS operands of the x word, y goes to all
    for (genvar t = 0; t < TAPU_NUM; t++) begin : g_tapu
        mac_array #(
            .ROWS(ROWS),
            .COLS(COLS)
        ) u_mac (
            .clk        (clk),
            .rst_n      (rst_n),
            .i_clr      (clr),
            .i_acc_en   (acc_en),
            .i_x        (x_rd_data[t*ROWS*OPND_W +: ROWS*OPND_W]),
            .i_y        (y_rd_data),
            .i_drain_row(drain_row),
            .o_row_data (row_data[t])
        );

        sync_fifo #(
            .WIDTH(RES_W),
            .DEPTH(RES_FIFO_DEPTH)
        ) u_res_fifo (
            .clk    (clk),
            .rst_n  (rst_n),
            .i_wr   (drain_wr),
            .i_din  (row_data[t]),
            .i_rd   (res_rd[t]),
            .o_dout (res_dout[t]),
            .o_empty(),
            .o_full ()
        );
    end

    store_ctrl #(
        .TAPU_NUM(TAPU_NUM),
        .ROWS    (ROWS),
        .COLS    (COLS)
    ) u_store_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_store_start(i_store_start),
        .i_res_dout   (res_dout),
        .o_res_rd     (res_rd),
        .i_out_full   (out_full),
        .o_out_wr     (out_wr),
        .o_out_data   (out_data),
        .o_out_last   (out_last),
        .o_store_done (o_store_done)
    );

    // last travels with its data word through the stream fifo
    sync_fifo #(
        .WIDTH(RES_W + 1),
        .DEPTH(OUT_FIFO_DEPTH)
    ) u_out_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_wr   (out_wr),
        .i_din  ({out_last, out_data}),
        .i_rd   (i_m_ready),
        .o_dout ({o_m_last, o_m_data}),
        .o_empty(out_empty),
        .o_full (out_full)
    );

    assign o_m_valid = ~out_empty;

endmodule

// ==== store_ctrl.sv ====
`timescale 1ns/1ns

module store_ctrl import core_pkg::*, ctrl_pkg::*; #(
    parameter int TAPU_NUM = 2,
    parameter int ROWS     = 2,
    parameter int COLS     = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   i_store_start,
    input  logic [TAPU_NUM-1:0][COLS*PSUM_W-1:0]   i_res_dout,
    output logic [TAPU_NUM-1:0]                    o_res_rd,
    input  logic                                   i_out_full,
    output logic                                   o_out_wr,
    output logic [COLS*PSUM_W-1:0]                 o_out_data,
    output logic                                   o_out_last,
    output logic                                   o_store_done
);

    localparam int TW = (TAPU_NUM > 1) ? $clog2(TAPU_NUM) : 1;

    store_state_t state;
    cnt_t         arr;
    cnt_t         row;

    // one word per cycle, held off while the output fifo is full
    assign o_out_wr     = (state == STORE_POP) & ~i_out_full;
    assign o_out_data   = i_res_dout[arr[TW-1:0]];
    assign o_out_last   = (arr == cnt_t'(TAPU_NUM - 1)) && (row == cnt_t'(ROWS - 1));
    assign o_store_done = (state == STORE_FINISH);

    always_comb begin
        for (int t = 0; t < TAPU_NUM; t++) begin
            o_res_rd[t] = o_out_wr && (arr == cnt_t'(t));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= STORE_IDLE;
            arr   <= '0;
            row   <= '0;
        end else begin
            case (state)
                STORE_IDLE: begin
                    if (i_store_start) begin
                        state <= STORE_POP;
                        arr   <= '0;
                        row   <= '0;
                    end
                end
                STORE_POP: begin
                    if (o_out_wr) begin
                        if (row == cnt_t'(ROWS - 1)) begin
                            row <= '0;
                            if (arr == cnt_t'(TAPU_NUM - 1)) begin
                                state <= STORE_FINISH;
                            end else begin
                                arr <= arr + 1'b1;
                            end
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end
                STORE_FINISH: state <= STORE_IDLE;
                default: state <= STORE_IDLE;
            endcase
        end
    end

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH = 128,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_wr,
    input  logic [WIDTH-1:0] i_din,
    input  logic             i_rd,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_empty,
    output logic             o_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_wr;
    logic             do_rd;

    // writes to a full fifo and reads from an empty one are dropped
    assign do_wr   = i_wr & ~o_full;
    assign do_rd   = i_rd & ~o_empty;
    assign o_empty = (count == '0);
    assign o_full  = (count == (AW + 1)'(DEPTH));

    // head word falls through; zero while empty
    assign o_dout = o_empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (AW + 1)'(do_wr) - (AW + 1)'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

endmodule

// ==== mac_array.sv ====
`timescale 1ns/1ns

module mac_array import core_pkg::*, ctrl_pkg::*; #(
    parameter int ROWS = 2,
    parameter int COLS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_clr,
    input  logic                 i_acc_en,
    input  opnd_t [ROWS-1:0]     i_x,
    input  opnd_t [COLS-1:0]     i_y,
    input  cnt_t                 i_drain_row,
    output psum_t [COLS-1:0]     o_row_data
);

    localparam int RW = (ROWS > 1) ? $clog2(ROWS) : 1;

    psum_t                     acc  [ROWS][COLS];
    logic signed [2*OPND_W-1:0] prod [ROWS][COLS];

    // x runs down the rows, y across the columns
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                prod[r][c] = $signed(i_x[r]) * $signed(i_y[c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    acc[r][c] <= '0;
                end
            end
        end else if (i_clr) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    acc[r][c] <= '0;
                end
            end
        end else if (i_acc_en) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    // product sign-extended to the sum width
                    acc[r][c] <= acc[r][c] + psum_t'(prod[r][c]);
                end
            end
        end
    end

    // drain mux, column 0 in the low bits
    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            o_row_data[c] = acc[i_drain_row[RW-1:0]][c];
        end
    end

endmodule

// ==== exec_ctrl.sv ====
`timescale 1ns/1ns

module exec_ctrl import ctrl_pkg::*; #(
    parameter int ROWS      = 2,
    parameter int BUF_DEPTH = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic i_exec_start,
    input  logic i_psu_clr,
    input  cnt_t i_depth,
    output cnt_t o_rd_addr,
    output logic o_acc_en,
    output logic o_clr,
    output cnt_t o_drain_row,
    output logic o_drain_wr,
    output logic o_exec_done
);

    exec_state_t state;
    cnt_t        depth_q;
    cnt_t        depth_sel;

    // keep K inside 1..BUF_DEPTH so the feed always terminates
    always_comb begin
        if (i_depth == '0) begin
            depth_sel = cnt_t'(1);
        end else if (i_depth > cnt_t'(BUF_DEPTH)) begin
            depth_sel = cnt_t'(BUF_DEPTH);
        end else begin
            depth_sel = i_depth;
        end
    end

    assign o_drain_wr = (state == EXEC_DRAIN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= EXEC_IDLE;
            depth_q     <= cnt_t'(1);
            o_rd_addr   <= '0;
            o_drain_row <= '0;
            o_acc_en    <= 1'b0;
            o_clr       <= 1'b0;
            o_exec_done <= 1'b0;
        end else begin
            // buffer data lags the address by one cycle
            o_acc_en    <= (state == EXEC_FEED);
            o_clr       <= 1'b0;
            o_exec_done <= (state == EXEC_DRAIN) && (o_drain_row == cnt_t'(ROWS - 1));
            case (state)
                EXEC_IDLE: begin
                    if (i_exec_start) begin
                        state     <= EXEC_FEED;
                        depth_q   <= depth_sel;
                        o_rd_addr <= '0;
                        o_clr     <= i_psu_clr;
                    end
                end
                EXEC_FEED: begin
                    if (o_rd_addr == depth_q - 1'b1) begin
                        state <= EXEC_FLUSH;
                    end else begin
                        o_rd_addr <= o_rd_addr + 1'b1;
                    end
                end
                // last accumulate lands here
                EXEC_FLUSH: begin
                    state       <= EXEC_DRAIN;
                    o_drain_row <= '0;
                end
                EXEC_DRAIN: begin
                    if (o_drain_row == cnt_t'(ROWS - 1)) begin
                        state <= EXEC_IDLE;
                    end else begin
                        o_drain_row <= o_drain_row + 1'b1;
                    end
                end
                default: state <= EXEC_IDLE;
            endcase
        end
    end

endmodule

// ==== operand_buf.sv ====
`timescale 1ns/1ns

module operand_buf import ctrl_pkg::*; #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    // load stream
    input  logic             i_valid,
    output logic             o_ready,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_last,
    output logic             o_load_done,
    // execution read port
    input  cnt_t             i_rd_addr,
    output logic [WIDTH-1:0] o_rd_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    cnt_t             wr_addr;

    // the buffer always accepts a beat
    assign o_ready = 1'b1;

    // write address restarts at 0 after a last beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_addr     <= '0;
            o_load_done <= 1'b0;
        end else begin
            o_load_done <= i_valid & i_last;
            if (i_valid) begin
                if (i_last || wr_addr == cnt_t'(DEPTH - 1)) begin
                    wr_addr <= '0;
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            mem[wr_addr[AW-1:0]] <= i_data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr[AW-1:0]];
    end

endmodule

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

    // execution sequence: feed operands, one flush cycle, then drain rows
    typedef enum logic [1:0] {
        EXEC_IDLE,
        EXEC_FEED,
        EXEC_FLUSH,
        EXEC_DRAIN
    } exec_state_t;

    // store sequence over the result fifos
    typedef enum logic [1:0] {
        STORE_IDLE,
        STORE_POP,
        STORE_FINISH
    } store_state_t;

    // depth, row and array indices
    typedef logic [7:0] cnt_t;

endpackage

// ==== core_pkg.sv ====
package core_pkg;

    // one int8 operand element
    localparam int OPND_W = 8;

    // accumulator width inside each mac cell
    localparam int PSUM_W = 32;

    // signed operand, as read from the X and Y buffers
    typedef logic signed [OPND_W-1:0] opnd_t;

    // signed partial sum; result words are COLS of these side by side
    typedef logic signed [PSUM_W-1:0] psum_t;

endpackage
